/* load_unit.f */
+incdir+common
common/load_unit_pkg.sv
load_buffer/ldbuf_slot.sv
src/load_req_ctrl.sv
src/load_rsp_align.sv
src/load_unit.sv
dv/tb_load_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f load_unit.f \
  --top-module tb_load_unit \
  --Mdir obj_dir -o sim_load_unit

./obj_dir/sim_load_unit | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
else
  exit 1
fi

/* dv/tb_load_unit.sv */
// --------------------------------------------------
// load unit testbench
//   clock, reset and random issue stage
//   data cache model with random grants and responses
//   scoreboard model and checking assertions
// --------------------------------------------------

`timescale 1ns/1ps
`include "load_unit_config.svh"

module tb_load_unit;

  localparam int NUM_LOADS      = 200;
  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int SEED           = 78336;
  localparam int NR             = `LU_NR_LDBUF;
  localparam int TIMEOUT_CYCLES = NUM_LOADS * 12 + 600;

  logic                       clk_i   = 1'b0;
  logic                       rst_ni  = 1'b0;
  logic                       flush_i = 1'b0;
  logic                       valid_i = 1'b0;
  load_unit_pkg::lsu_req_t    req_i   = '0;
  load_unit_pkg::dcache_rsp_t rsp_i   = '0;
  logic                       pop_o;
  load_unit_pkg::dcache_req_t req_o;
  load_unit_pkg::ld_result_t  wb_o;

  // model of the slots as the issue side and the cache see them
  logic [NR-1:0]                 live    = '0;
  logic [NR-1:0]                 flushed = '0;
  logic [NR-1:0]                 pend    = '0;
  logic [`LU_ADDR_WIDTH-1:0]     slot_addr [NR];
  load_unit_pkg::ld_op_e         slot_op [NR];
  logic [`LU_TRANS_ID_BITS-1:0]  slot_tid [NR];
  int                            rsp_timer [NR];

  // what the DUT must show in the current cycle
  logic                          exp_valid = 1'b0;
  logic [`LU_TRANS_ID_BITS-1:0]  exp_tid   = '0;
  logic [`LU_XLEN-1:0]           exp_result = '0;
  logic [`LU_TAG_WIDTH-1:0]      exp_tag   = '0;

  int errors     = 0;
  int n_issued   = 0;
  int n_expected = 0;
  int n_results  = 0;
  int cycles     = 0;
  int low_cnt    = 0;
  bit holding    = 1'b0;
  bit done       = 1'b0;
  bit seeded     = 1'b0;

  load_unit i_load_unit (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .valid_i(valid_i),
    .req_i  (req_i),
    .pop_o  (pop_o),
    .rsp_i  (rsp_i),
    .req_o  (req_o),
    .wb_o   (wb_o)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // each byte is the low byte of the word address mixed with its byte number
  function automatic logic [`LU_XLEN-1:0] word_data(logic [`LU_ADDR_WIDTH-1:0] addr);
    logic [`LU_XLEN-1:0] w;
    w = '0;
    for (int b = 0; b < 8; b++) begin
      w[8*b +: 8] = addr[10:3] ^ 8'(b) ^ 8'hA5;
    end
    return w;
  endfunction

  // byte field at the offset, extended as the load kind asks
  function automatic logic [`LU_XLEN-1:0] predict(logic [`LU_ADDR_WIDTH-1:0] addr,
                                                  load_unit_pkg::ld_op_e op);
    logic [`LU_XLEN-1:0] f;
    f = word_data(addr) >> (8 * int'(addr[2:0]));
    case (op)
      load_unit_pkg::LW:  return {{32{f[31]}}, f[31:0]};
      load_unit_pkg::LWU: return {32'h0, f[31:0]};
      load_unit_pkg::LH:  return {{48{f[15]}}, f[15:0]};
      load_unit_pkg::LHU: return {48'h0, f[15:0]};
      load_unit_pkg::LB:  return {{56{f[7]}}, f[7:0]};
      load_unit_pkg::LBU: return {56'h0, f[7:0]};
      default:            return f;
    endcase
  endfunction

  // size code from the number of enabled bytes, 1 2 4 8 give 0 1 2 3
  function automatic logic [1:0] size_of_be(logic [(`LU_XLEN/8)-1:0] be);
    case ($countones(be))
      1:       return 2'd0;
      2:       return 2'd1;
      4:       return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // random load with an offset that is naturally aligned for its size
  function automatic load_unit_pkg::lsu_req_t random_load(int tid);
    load_unit_pkg::lsu_req_t r;
    r.op       = load_unit_pkg::ld_op_e'($urandom % 7);
    r.vaddr    = $urandom;
    r.trans_id = 3'(tid);
    case (r.op)
      load_unit_pkg::LW, load_unit_pkg::LWU: begin
        r.vaddr[1:0] = 2'b00;
        r.be = 8'h0F << r.vaddr[2:0];
      end
      load_unit_pkg::LH, load_unit_pkg::LHU: begin
        r.vaddr[0] = 1'b0;
        r.be = 8'h03 << r.vaddr[2:0];
      end
      load_unit_pkg::LB, load_unit_pkg::LBU: r.be = 8'h01 << r.vaddr[2:0];
      default: begin
        r.vaddr[2:0] = 3'b000;
        r.be = 8'hFF;
      end
    endcase
    return r;
  endfunction

  // --------------------------------------------------
  // issue stage, cache model and scoreboard
  // --------------------------------------------------
  always @(posedge clk_i) begin : model
    int ready [$];
    int id;
    bit drive_flush;
    // all random numbers of the run come from this process
    if (!seeded) begin
      void'($urandom(SEED));
      seeded = 1'b1;
    end
    if (rst_ni) begin
      cycles++;
      // a flush marks every load that is outstanding in the flush cycle
      if (flush_i) begin
        flushed = flushed | live;
      end
      if (rsp_i.data_rvalid) begin
        live[rsp_i.data_rid] = 1'b0;
      end
      if (wb_o.valid) begin
        n_results++;
      end
      if (pop_o) begin
        id = int'(req_o.data_id);
        live[id]      = 1'b1;
        flushed[id]   = 1'b0;
        pend[id]      = 1'b1;
        slot_addr[id] = req_i.vaddr;
        slot_op[id]   = req_i.op;
        slot_tid[id]  = req_i.trans_id;
        // one tag cycle, then 1 to 6 cycles until the answer
        rsp_timer[id] = 2 + int'($urandom % 6);
        exp_tag <= req_i.vaddr[`LU_INDEX_WIDTH +: `LU_TAG_WIDTH];
        valid_i <= 1'b0;
        holding = 1'b0;
        n_issued++;
      end

      // grant after at most three cycles of waiting
      if (req_o.data_req && !rsp_i.data_gnt) begin
        low_cnt++;
      end else begin
        low_cnt = 0;
      end
      rsp_i.data_gnt <= (low_cnt >= 3) || ($urandom % 2 == 0);

      drive_flush = !flush_i && (n_issued > 0) && ($urandom % 50 == 0);
      flush_i <= drive_flush;

      // answer one ready slot in random order, never in a flush cycle
      ready.delete();
      for (int i = 0; i < NR; i++) begin
        if (pend[i]) begin
          if (rsp_timer[i] > 0) begin
            rsp_timer[i]--;
          end
          if (rsp_timer[i] == 0) begin
            ready.push_back(i);
          end
        end
      end
      if (!drive_flush && ready.size() > 0) begin
        id = ready[$urandom % ready.size()];
        pend[id] = 1'b0;
        rsp_i.data_rvalid <= 1'b1;
        rsp_i.data_rid    <= `LU_LDBUF_ID_BITS'(id);
        rsp_i.data_rdata  <= word_data(slot_addr[id]);
        exp_valid  <= !flushed[id];
        exp_tid    <= slot_tid[id];
        exp_result <= predict(slot_addr[id], slot_op[id]);
        if (!flushed[id]) begin
          n_expected++;
        end
      end else begin
        rsp_i.data_rvalid <= 1'b0;
        exp_valid <= 1'b0;
      end

      // the issue stage holds each load until it is popped
      if (!holding && n_issued < NUM_LOADS && ($urandom % 4 != 0)) begin
        valid_i <= 1'b1;
        req_i   <= random_load(n_issued);
        holding = 1'b1;
      end

      done = (n_issued == NUM_LOADS) && !holding && (live == '0) && (pend == '0);
    end
  end

  // --------------------------------------------------
  // checking assertions
  // --------------------------------------------------
  a_wb_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.valid == exp_valid)
    else begin
      errors++;
      $display("[ERROR] wb_valid expected %0h actual %0h",
               $sampled(exp_valid), $sampled(wb_o.valid));
    end

  a_wb_tid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_valid |-> wb_o.trans_id == exp_tid)
    else begin
      errors++;
      $display("[ERROR] wb_trans_id expected %0h actual %0h",
               $sampled(exp_tid), $sampled(wb_o.trans_id));
    end

  a_wb_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_valid |-> wb_o.result == exp_result)
    else begin
      errors++;
      $display("[ERROR] wb_result expected %0h actual %0h",
               $sampled(exp_result), $sampled(wb_o.result));
    end

  // index, byte enables and size of a request follow the load held by the issue stage
  a_req_index: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.data_req |-> req_o.address_index == req_i.vaddr[`LU_INDEX_WIDTH-1:0])
    else begin
      errors++;
      $display("[ERROR] address_index expected %0h actual %0h",
               $sampled(req_i.vaddr[`LU_INDEX_WIDTH-1:0]), $sampled(req_o.address_index));
    end

  a_req_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.data_req |-> req_o.data_be == req_i.be)
    else begin
      errors++;
      $display("[ERROR] data_be expected %0h actual %0h",
               $sampled(req_i.be), $sampled(req_o.data_be));
    end

  a_req_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.data_req |-> req_o.data_size == size_of_be(req_i.be))
    else begin
      errors++;
      $display("[ERROR] data_size expected %0h actual %0h",
               size_of_be($sampled(req_i.be)), $sampled(req_o.data_size));
    end

  // tag follows each grant, and appears only after a grant or a flush
  a_tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o.data_req && rsp_i.data_gnt) |=> req_o.tag_valid)
    else begin
      errors++;
      $display("tag_valid did not follow a granted request");
    end

  a_tag_origin: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.tag_valid |-> ($past(req_o.data_req && rsp_i.data_gnt) || $past(flush_i)))
    else begin
      errors++;
      $display("tag_valid was raised without a grant or a flush before it");
    end

  a_tag_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o.tag_valid && !req_o.kill_req) |-> req_o.address_tag == exp_tag)
    else begin
      errors++;
      $display("[ERROR] address_tag expected %0h actual %0h",
               $sampled(exp_tag), $sampled(req_o.address_tag));
    end

  a_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&live) |-> !req_o.data_req)
    else begin
      errors++;
      $display("data_req was raised while all slots were outstanding");
    end

  a_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_o |-> (req_o.data_req && rsp_i.data_gnt))
    else begin
      errors++;
      $display("pop_o was raised without a granted request");
    end

  a_id_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_o |-> !live[req_o.data_id])
    else begin
      errors++;
      $display("a request was granted on a slot that was still outstanding");
    end

  a_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (req_o.kill_req && req_o.tag_valid))
    else begin
      errors++;
      $display("kill_req and tag_valid did not follow a flush");
    end

  a_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(req_o.data_req || req_o.tag_valid || req_o.kill_req || pop_o || wb_o.valid))
    else begin
      errors++;
      $display("an output strobe was high during reset");
    end

  // --------------------------------------------------
  // reset, run limit and final report
  // --------------------------------------------------
  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("errors=%0d loads=%0d expected_results=%0d results=%0d",
             errors, n_issued, n_expected, n_results);
    if (!done) begin
      $display("timeout after %0d cycles with loads still outstanding", cycles);
      $display("RESULT: FAIL");
    end else if (errors != 0 || n_results != n_expected) begin
      if (n_results != n_expected) begin
        $display("the number of writebacks differs from the unflushed loads");
      end
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

/* src/load_unit.sv */
// --------------------------------------------------
// load unit top level
//   request controller towards the data cache
//   buffer of outstanding load slots
//   response aligner and writeback
// --------------------------------------------------

`timescale 1ns/1ps
`include "load_unit_config.svh"

module load_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  // issue stage
  input  logic                       valid_i,
  input  load_unit_pkg::lsu_req_t    req_i,
  output logic                       pop_o,
  // data cache port
  input  load_unit_pkg::dcache_rsp_t rsp_i,
  output load_unit_pkg::dcache_req_t req_o,
  // writeback
  output load_unit_pkg::ld_result_t  wb_o
);

  // slot state seen by the controller and the aligner
  logic [`LU_NR_LDBUF-1:0]                   slot_valid;
  logic [`LU_NR_LDBUF-1:0]                   slot_flushed;
  load_unit_pkg::ldbuf_entry_t [`LU_NR_LDBUF-1:0] slot_entries;

  // allocation from the request side
  logic                         alloc_we;
  logic [`LU_LDBUF_ID_BITS-1:0] alloc_id;
  load_unit_pkg::ldbuf_entry_t  alloc_entry;
  logic                         flush_all;

  // release from the response side
  logic                         free_we;
  logic [`LU_LDBUF_ID_BITS-1:0] free_id;

  load_req_ctrl i_load_req_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .valid_i      (valid_i),
    .req_i        (req_i),
    .gnt_i        (rsp_i.data_gnt),
    .slot_valid_i (slot_valid),
    .pop_o        (pop_o),
    .req_o        (req_o),
    .alloc_we_o   (alloc_we),
    .alloc_id_o   (alloc_id),
    .alloc_entry_o(alloc_entry),
    .flush_all_o  (flush_all)
  );

  // --------------------------------------------------
  // outstanding load slots
  // --------------------------------------------------
  for (genvar i = 0; i < `LU_NR_LDBUF; i++) begin : gen_slot
    // each slot only reacts to strobes addressed to its own number
    logic slot_we;
    logic slot_free;

    assign slot_we   = alloc_we && (alloc_id == `LU_LDBUF_ID_BITS'(i));
    assign slot_free = free_we && (free_id == `LU_LDBUF_ID_BITS'(i));

    ldbuf_slot i_ldbuf_slot (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .we_i     (slot_we),
      .free_i   (slot_free),
      .flush_i  (flush_all),
      .entry_i  (alloc_entry),
      .valid_o  (slot_valid[i]),
      .flushed_o(slot_flushed[i]),
      .entry_o  (slot_entries[i])
    );
  end

  load_rsp_align i_load_rsp_align (
    .rsp_i    (rsp_i),
    .entries_i(slot_entries),
    .flushed_i(slot_flushed),
    .free_we_o(free_we),
    .free_id_o(free_id),
    .wb_o     (wb_o)
  );

endmodule

/* src/load_rsp_align.sv */
// --------------------------------------------------
// load response aligner
//   slot lookup by response id and slot release
//   byte realignment and sign or zero extension
//   writeback valid with flushed slots dropped
// --------------------------------------------------

`timescale 1ns/1ps
`include "load_unit_config.svh"

module load_rsp_align (
  input  load_unit_pkg::dcache_rsp_t                    rsp_i,
  input  load_unit_pkg::ldbuf_entry_t [`LU_NR_LDBUF-1:0] entries_i,
  input  logic [`LU_NR_LDBUF-1:0]                       flushed_i,
  output logic                                          free_we_o,
  output logic [`LU_LDBUF_ID_BITS-1:0]                  free_id_o,
  output load_unit_pkg::ld_result_t                     wb_o
);

  load_unit_pkg::ldbuf_entry_t sel;
  logic [`LU_XLEN-1:0]         shifted;
  logic [(`LU_XLEN/8)-1:0]     sign_bits;
  logic [`LU_OFFSET_BITS-1:0]  sign_offset;
  logic                        is_signed;
  logic                        sign_bit;

  // --------------------------------------------------
  // slot lookup
  // --------------------------------------------------
  assign sel = entries_i[rsp_i.data_rid];

  // the answered slot is released whether or not it was flushed
  assign free_we_o = rsp_i.data_rvalid;
  assign free_id_o = rsp_i.data_rid;

  // --------------------------------------------------
  // realignment and extension
  // --------------------------------------------------
  // move the addressed byte down to bit 0
  assign shifted = rsp_i.data_rdata >> {sel.addr_offset, 3'b000};

  // top bit of every byte, one of them is the sign of the loaded field
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rsp_i.data_rdata[8*i+7];
  end

  assign is_signed = sel.op inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};

  // the byte holding the sign is the highest byte of the field
  always_comb begin
    case (sel.op)
      load_unit_pkg::LW, load_unit_pkg::LWU: sign_offset = sel.addr_offset + 3'd3;
      load_unit_pkg::LH, load_unit_pkg::LHU: sign_offset = sel.addr_offset + 3'd1;
      default:                               sign_offset = sel.addr_offset;
    endcase
  end

  // picked beside the shifter instead of after it, unsigned loads force zero
  assign sign_bit = is_signed & sign_bits[sign_offset];

  always_comb begin
    wb_o.valid    = rsp_i.data_rvalid && !flushed_i[rsp_i.data_rid];
    wb_o.trans_id = sel.trans_id;
    case (sel.op)
      load_unit_pkg::LW, load_unit_pkg::LWU: begin
        wb_o.result = {{(`LU_XLEN-32){sign_bit}}, shifted[31:0]};
      end
      load_unit_pkg::LH, load_unit_pkg::LHU: begin
        wb_o.result = {{(`LU_XLEN-16){sign_bit}}, shifted[15:0]};
      end
      load_unit_pkg::LB, load_unit_pkg::LBU: begin
        wb_o.result = {{(`LU_XLEN-8){sign_bit}}, shifted[7:0]};
      end
      // a double word is already in place
      default: wb_o.result = shifted;
    endcase
  end

endmodule

/* src/load_req_ctrl.sv */
// --------------------------------------------------
// load request controller
//   request FSM with grant handshake and tag cycle
//   lowest free slot selection
//   tag register and flush kill sequence
// --------------------------------------------------

`timescale 1ns/1ps
`include "load_unit_config.svh"

module load_req_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         valid_i,
  input  load_unit_pkg::lsu_req_t      req_i,
  input  logic                         gnt_i,
  input  logic [`LU_NR_LDBUF-1:0]      slot_valid_i,
  output logic                         pop_o,
  output load_unit_pkg::dcache_req_t   req_o,
  output logic                         alloc_we_o,
  output logic [`LU_LDBUF_ID_BITS-1:0] alloc_id_o,
  output load_unit_pkg::ldbuf_entry_t  alloc_entry_o,
  output logic                         flush_all_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_e;

  state_e state_d, state_q;

  logic                         full;
  logic                         accept;
  logic                         granted;
  logic [`LU_LDBUF_ID_BITS-1:0] free_id;
  logic [`LU_TAG_WIDTH-1:0]     tag_q;

  // --------------------------------------------------
  // free slot selection
  // --------------------------------------------------
  assign full = &slot_valid_i;

  // scan from the top so that the lowest free slot wins
  always_comb begin
    free_id = '0;
    for (int i = `LU_NR_LDBUF - 1; i >= 0; i--) begin
      if (!slot_valid_i[i]) begin
        free_id = `LU_LDBUF_ID_BITS'(i);
      end
    end
  end

  // a new load starts only with a free slot and outside a flush cycle
  assign accept = valid_i && !full && !flush_i;

  // --------------------------------------------------
  // request FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;

    // index, byte enables and size come straight from the issued load
    req_o.data_req      = 1'b0;
    req_o.address_index = req_i.vaddr[`LU_INDEX_WIDTH-1:0];
    req_o.address_tag   = tag_q;
    req_o.data_be       = req_i.be;
    req_o.data_size     = load_unit_pkg::transfer_size(req_i.op);
    req_o.data_id       = free_id;
    req_o.kill_req      = 1'b0;
    req_o.tag_valid     = 1'b0;

    case (state_q)
      IDLE: begin
        if (accept) begin
          req_o.data_req = 1'b1;
          state_d        = gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end

      // the request stays up until the cache grants it
      WAIT_GNT: begin
        req_o.data_req = 1'b1;
        if (gnt_i) begin
          state_d = SEND_TAG;
        end
      end

      // the tag of last cycle's grant goes out, and the next load may start
      SEND_TAG: begin
        req_o.tag_valid = 1'b1;
        state_d         = IDLE;
        if (accept) begin
          req_o.data_req = 1'b1;
          state_d        = gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end

      // kill whatever request the cache may still hold
      WAIT_FLUSH: begin
        req_o.kill_req  = 1'b1;
        req_o.tag_valid = 1'b1;
        state_d         = IDLE;
      end

      default: state_d = IDLE;
    endcase

    // a flush withdraws a pending request, the kill follows next cycle
    if (flush_i) begin
      req_o.data_req = 1'b0;
      state_d        = WAIT_FLUSH;
    end
  end

  // the load leaves the issue stage in its grant cycle
  assign granted = req_o.data_req && gnt_i;
  assign pop_o   = granted;

  // --------------------------------------------------
  // slot allocation
  // --------------------------------------------------
  assign alloc_we_o                = granted;
  assign alloc_id_o                = free_id;
  assign alloc_entry_o.trans_id    = req_i.trans_id;
  assign alloc_entry_o.addr_offset = req_i.vaddr[`LU_OFFSET_BITS-1:0];
  assign alloc_entry_o.op          = req_i.op;

  // every occupied slot is marked in the flush cycle
  assign flush_all_o = flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag bits sit above the index and are sent one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (granted) begin
      tag_q <= req_i.vaddr[`LU_INDEX_WIDTH+`LU_TAG_WIDTH-1:`LU_INDEX_WIDTH];
    end
  end

endmodule

/* load_buffer/ldbuf_slot.sv */
// --------------------------------------------------
// one outstanding load slot
//   valid and flushed flags
//   stored entry for the response side
// --------------------------------------------------

`timescale 1ns/1ps

module ldbuf_slot (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        we_i,
  input  logic                        free_i,
  input  logic                        flush_i,
  input  load_unit_pkg::ldbuf_entry_t entry_i,
  output logic                        valid_o,
  output logic                        flushed_o,
  output load_unit_pkg::ldbuf_entry_t entry_o
);

  logic                        valid_q;
  logic                        flushed_q;
  load_unit_pkg::ldbuf_entry_t entry_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      flushed_q <= 1'b0;
    end else if (we_i) begin
      // a new load always starts clean, even in a flush cycle
      valid_q   <= 1'b1;
      flushed_q <= 1'b0;
    end else begin
      if (free_i) begin
        valid_q <= 1'b0;
      end
      // stays valid so that the late response can still free the slot
      if (flush_i && valid_q) begin
        flushed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      entry_q <= entry_i;
    end
  end

  assign valid_o   = valid_q;
  assign flushed_o = flushed_q;
  assign entry_o   = entry_q;

endmodule

/* common/load_unit_pkg.sv */
// --------------------------------------------------
// load unit package
//   load operation encoding
//   issue, slot, cache and writeback structs
//   transfer size function for the cache request
// --------------------------------------------------

`include "load_unit_config.svh"

package load_unit_pkg;

  // kinds of integer load, the U variants zero-extend
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_e;

  // a load as handed over by the issue stage
  typedef struct packed {
    logic [`LU_ADDR_WIDTH-1:0]    vaddr;
    logic [(`LU_XLEN/8)-1:0]      be;
    ld_op_e                       op;
    logic [`LU_TRANS_ID_BITS-1:0] trans_id;
  } lsu_req_t;

  // what an outstanding load needs to be finished when its data returns
  typedef struct packed {
    logic [`LU_TRANS_ID_BITS-1:0] trans_id;
    logic [`LU_OFFSET_BITS-1:0]   addr_offset;
    ld_op_e                       op;
  } ldbuf_entry_t;

  // request side of the data cache port
  typedef struct packed {
    logic                         data_req;
    logic [`LU_INDEX_WIDTH-1:0]   address_index;
    logic [`LU_TAG_WIDTH-1:0]     address_tag;
    logic [(`LU_XLEN/8)-1:0]      data_be;
    logic [1:0]                   data_size;
    logic [`LU_LDBUF_ID_BITS-1:0] data_id;
    logic                         kill_req;
    logic                         tag_valid;
  } dcache_req_t;

  // response side of the data cache port
  typedef struct packed {
    logic                         data_gnt;
    logic                         data_rvalid;
    logic [`LU_LDBUF_ID_BITS-1:0] data_rid;
    logic [`LU_XLEN-1:0]          data_rdata;
  } dcache_rsp_t;

  // writeback towards the scoreboard
  typedef struct packed {
    logic                         valid;
    logic [`LU_TRANS_ID_BITS-1:0] trans_id;
    logic [`LU_XLEN-1:0]          result;
  } ld_result_t;

  // size code of the cache port: 0 byte, 1 half, 2 word, 3 double
  function automatic logic [1:0] transfer_size(ld_op_e op);
    case (op)
      LW, LWU: return 2'b10;
      LH, LHU: return 2'b01;
      LB, LBU: return 2'b00;
      default: return 2'b11;
    endcase
  endfunction

endpackage

/* common/load_unit_config.svh */
// --------------------------------------------------
// load unit configuration macros
//   data and address widths
//   number of load buffer slots and id widths
//   split of the load address into cache fields
// --------------------------------------------------

`ifndef LOAD_UNIT_CONFIG_SVH
`define LOAD_UNIT_CONFIG_SVH

// width of a data word and of a load address
`define LU_XLEN 64
`define LU_ADDR_WIDTH 32

// outstanding loads, the slot id must encode all of them
`define LU_NR_LDBUF 4
`define LU_LDBUF_ID_BITS 2

// scoreboard transaction id width
`define LU_TRANS_ID_BITS 3

// cache address split, index in the low bits and tag above it
`define LU_INDEX_WIDTH 12
`define LU_TAG_WIDTH 20
`define LU_OFFSET_BITS 3

`endif
